// File: vlog.f
+incdir+verilog
verilog/trig_cmd_pkg.sv
verilog/trig_cmd_phase_gen.sv
verilog/trig_cmd_wb_regs.sv
verilog/trig_cmd_encoder.sv
verilog/trig_cmd_top.sv
verification/tb_clkgen.sv
verification/trig_cmd_assertions.sv
verification/trig_cmd_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= trig_cmd_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Regression passed

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the result comes from the pass message, not the exit code
run: compile
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/trig_cmd_tb.sv
`timescale 1ns/1ps
`include "trig_cmd_defines.svh"

module trig_cmd_tb import trig_cmd_pkg::*; ();

    localparam logic [31:0] SEED = 32'h530c6e94;
    localparam int ACK_TIMEOUT = 200;
    localparam logic [7:0] ADR_RUNCMD = {4'd0, `TRIG_CMD_ADDR_RUNCMD, 2'b00};
    localparam logic [7:0] ADR_FWU = {4'd0, `TRIG_CMD_ADDR_FWU, 2'b00};
    localparam logic [7:0] ADR_CONTROL = {4'd0, `TRIG_CMD_ADDR_CONTROL, 2'b00};
    localparam logic [7:0] ADR_RESERVED = {4'd0, `TRIG_CMD_ADDR_RESERVED, 2'b00};

    logic        sysclk;
    logic        wb_rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [7:0]  wb_adr;
    logic [3:0]  wb_sel;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        pps;
    logic        trig_valid;
    logic [15:0] trig_data;
    logic        trig_ready;
    logic        runrst;
    logic        runstop;
    cmd_word_t   command;
    logic        phase;

    // reference model state
    wb_state_e   m_state;
    logic        m_ctrl;
    logic        m_pps_q;
    logic [7:0]  m_hold_data;
    logic        m_hold_mark;
    logic        m_run_pend;
    logic [1:0]  m_run_val;
    logic        m_fwu_pend;
    logic        m_fwu_mark;
    logic [7:0]  m_fwu_data;
    cmd_word_t   m_word;
    int          m_cycle;
    int          m_phases;
    int          n_runrst;
    int          n_runstop;
    // trigger accepted in the last cycle
    logic        trig_taken;
    logic [31:0] rng;
    logic [31:0] trig_rng;
    logic        ctrl_exp;

    tb_clkgen clkgen_inst (
        .clk_o (sysclk),
        .rst_o (wb_rst)
    );

    trig_cmd_top trig_cmd_top_inst (
        .sysclk_i        (sysclk),
        .wb_rst_i        (wb_rst),
        .wb_cyc_i        (wb_cyc),
        .wb_stb_i        (wb_stb),
        .wb_we_i         (wb_we),
        .wb_adr_i        (wb_adr),
        .wb_sel_i        (wb_sel),
        .wb_dat_i        (wb_dat_w),
        .wb_dat_o        (wb_dat_r),
        .wb_ack_o        (wb_ack),
        .pps_i           (pps),
        .s_trig_tvalid_i (trig_valid),
        .s_trig_tdata_i  (trig_data),
        .s_trig_tready_o (trig_ready),
        .runrst_o        (runrst),
        .runstop_o       (runstop),
        .command_o       (command),
        .phase_o         (phase)
    );

    bind trig_cmd_top trig_cmd_assertions assertions_inst (
        .sysclk_i  (sysclk_i),
        .wb_rst_i  (wb_rst_i),
        .wb_ack_i  (wb_ack_o),
        .runrst_i  (runrst_o),
        .runstop_i (runstop_o),
        .phase_i   (phase_o),
        .tvalid_i  (s_trig_tvalid_i),
        .tready_i  (s_trig_tready_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Regression failed");
            $fatal(1, "value mismatch on %s", what);
        end
    endtask

    task automatic model_reset();
        m_state    = WB_IDLE;
        m_ctrl     = 1'b0;
        m_pps_q    = 1'b0;
        m_run_pend = 1'b0;
        m_fwu_pend = 1'b0;
        m_word     = '0;
        m_cycle    = 0;
        m_phases   = 0;
    endtask

    // one clock cycle of the model
    // sampled mid-cycle after the inputs settle
    task automatic model_step();
        logic       exp_phase;
        logic       sync;
        logic       emit;
        logic [1:0] run_out;
        logic       done;
        logic [1:0] slot;
        logic       req;
        exp_phase = (m_cycle % `TRIG_CMD_PHASE_PERIOD) == `TRIG_CMD_PHASE_PERIOD - 1;
        // sync covers the last strobe of every group
        sync    = (m_phases % `TRIG_CMD_SYNC_PHASES) == `TRIG_CMD_SYNC_PHASES - 1;
        emit    = m_run_pend && sync;
        run_out = emit ? m_run_val : 2'd0;
        done    = exp_phase && (emit || m_fwu_pend);
        slot    = wb_adr[3:2];
        req     = wb_cyc && wb_stb;

        check_value("phase_o", 32'(phase), 32'(exp_phase));
        check_value("command_o", command, m_word);
        check_value("wb_ack_o", 32'(wb_ack), 32'(m_state == WB_ACK));
        check_value("wb_dat_o", wb_dat_r, {31'd0, m_ctrl});
        check_value("s_trig_tready_o", 32'(trig_ready), 32'(trig_valid && exp_phase));
        check_value("runrst_o", 32'(runrst), 32'(exp_phase && run_out == 2'd2));
        check_value("runstop_o", 32'(runstop), 32'(exp_phase && run_out == 2'd3));

        // next word loaded at the end of a phase cycle
        if (exp_phase) begin
            m_word.no_msg     = !(emit || m_fwu_pend || m_pps_q);
            m_word.pps        = m_pps_q;
            m_word.rsvd       = 2'b00;
            m_word.runcmd     = runcmd_e'(run_out);
            m_word.mode1_type = MODE1_NOOP;
            m_word.mode1_data = 8'd0;
            if (m_fwu_pend && !m_fwu_mark) begin
                m_word.mode1_type = MODE1_FWU_DATA;
                m_word.mode1_data = m_fwu_data;
            end else if (m_fwu_pend) begin
                m_word.mode1_data = {6'd0, 1'b1, m_fwu_data[0]};
            end
            m_word.trig_valid = trig_valid;
            m_word.trig_addr  = trig_data[14:0];
        end

        // pps sees the control bit from before this edge
        m_pps_q = pps && m_ctrl;
        if (m_state == WB_ACK && slot == `TRIG_CMD_ADDR_CONTROL && wb_we && wb_sel[0]) begin
            m_ctrl = wb_dat_w[0];
        end
        if (m_state == WB_IDLE && req && wb_we) begin
            if (wb_sel[0]) begin
                m_hold_data = wb_dat_w[7:0];
            end
            if (wb_sel[3]) begin
                m_hold_mark = wb_dat_w[31];
            end
        end
        // a send in the same cycle wins over retiring
        if (m_state == WB_ISSUE && slot == `TRIG_CMD_ADDR_RUNCMD) begin
            m_run_pend = 1'b1;
            m_run_val  = m_hold_data[1:0];
        end else if (exp_phase && sync) begin
            m_run_pend = 1'b0;
        end
        if (m_state == WB_ISSUE && slot == `TRIG_CMD_ADDR_FWU) begin
            m_fwu_pend = 1'b1;
            m_fwu_mark = m_hold_mark;
            m_fwu_data = m_hold_data;
        end else if (exp_phase) begin
            m_fwu_pend = 1'b0;
        end

        case (m_state)
            WB_IDLE: begin
                if (req && (slot == `TRIG_CMD_ADDR_CONTROL || slot == `TRIG_CMD_ADDR_RESERVED
                            || !(wb_we && wb_sel[0]))) begin
                    m_state = WB_ACK;
                end else if (req) begin
                    m_state = WB_ISSUE;
                end
            end
            WB_ISSUE: m_state = WB_WAIT;
            WB_WAIT: m_state = done ? WB_ACK : WB_WAIT;
            default: m_state = WB_IDLE;
        endcase

        n_runrst  += int'(runrst);
        n_runstop += int'(runstop);
        if (trig_ready) begin
            trig_taken = 1'b1;
        end
        if (exp_phase) begin
            m_phases++;
        end
        m_cycle++;
    endtask

    // model runs 1 ns after each falling edge
    always @(negedge sysclk) begin
        #1;
        if (wb_rst !== 1'b0) begin
            model_reset();
        end else begin
            model_step();
        end
    end

    // the bound checker counts its failed assertions
    always @(negedge sysclk) begin
        if (trig_cmd_top_inst.assertions_inst.fail_count != 0) begin
            $display("Regression failed");
            $fatal(1, "a concurrent assertion on the DUT failed");
        end
    end

    // trigger source holds its data until accepted
    // idle through reset and on the release edge itself
    always @(negedge sysclk) begin
        if (wb_rst !== 1'b0 || m_cycle == 0) begin
            trig_valid = 1'b0;
            trig_data  = 16'd0;
            trig_taken = 1'b0;
        end else if (!trig_valid || trig_taken) begin
            trig_rng   = xorshift32(trig_rng);
            trig_valid = trig_rng[0];
            trig_data  = trig_rng[31:16];
            trig_taken = 1'b0;
        end
    end

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge sysclk);
    endtask

    // one wishbone cycle
    // lat counts falling edges until ack
    task automatic wb_access(input logic we, input logic [7:0] adr, input logic [3:0] sel,
                             input logic [31:0] dat, output logic [31:0] rdata,
                             output int lat);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_sel   = sel;
        wb_dat_w = dat;
        lat      = 0;
        do begin
            @(negedge sysclk);
            lat++;
            if (lat > ACK_TIMEOUT) begin
                $display("Regression failed");
                $fatal(1, "no wishbone ack within %0d cycles", ACK_TIMEOUT);
            end
        end while (!wb_ack);
        rdata  = wb_dat_r;
        // address and data stay put through the ack edge
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        @(negedge sysclk);
        wb_we  = 1'b0;
    endtask

    initial begin
        logic [31:0] rd;
        int          lat;
        int          before_rst;
        int          before_stop;
        int          wait_cnt;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = 8'd0;
        wb_sel     = 4'd0;
        wb_dat_w   = 32'd0;
        pps        = 1'b0;
        trig_valid = 1'b0;
        trig_data  = 16'd0;
        trig_taken = 1'b0;
        n_runrst   = 0;
        n_runstop  = 0;
        rng        = SEED;
        trig_rng   = xorshift32(~SEED);

        wait_cnt = 0;
        while (wb_rst !== 1'b0) begin
            @(posedge sysclk);
            wait_cnt++;
            if (wait_cnt > 16) begin
                $display("Regression failed");
                $fatal(1, "reset was never released");
            end
        end
        @(negedge sysclk);
        // let the first words go out with nothing pending
        idle_cycles(20);

        // control bit read back from random addresses
        for (int i = 0; i < 8; i++) begin
            rng      = xorshift32(rng);
            ctrl_exp = rng[0];
            wb_access(1'b1, ADR_CONTROL, 4'hf, rng, rd, lat);
            check_value("control write latency", lat, 1);
            wb_access(1'b0, rng[15:8], 4'hf, 32'd0, rd, lat);
            check_value("control readback", rd, {31'd0, ctrl_exp});
            check_value("read latency", lat, 1);
            wb_access(1'b1, ADR_RESERVED, 4'hf, ~rng, rd, lat);
            check_value("reserved write latency", lat, 1);
            wb_access(1'b0, rng[23:16], 4'hf, 32'd0, rd, lat);
            check_value("readback after reserved write", rd, {31'd0, ctrl_exp});
        end

        // run commands only go out in a sync interval
        for (int i = 0; i < 10; i++) begin
            rng         = xorshift32(rng);
            before_rst  = n_runrst;
            before_stop = n_runstop;
            idle_cycles(int'(rng[6:4]));
            wb_access(1'b1, ADR_RUNCMD, 4'hf, rng, rd, lat);
            check_value("runrst_o pulse count", n_runrst - before_rst, 32'(rng[1:0] == 2'd2));
            check_value("runstop_o pulse count", n_runstop - before_stop, 32'(rng[1:0] == 2'd3));
        end
        // without byte 0 nothing is issued
        wb_access(1'b1, ADR_RUNCMD, 4'he, 32'h3, rd, lat);
        check_value("runcmd write without sel 0 latency", lat, 1);

        // fwu data bytes and marks
        for (int i = 0; i < 12; i++) begin
            rng = xorshift32(rng);
            idle_cycles(int'(rng[10:8]));
            wb_access(1'b1, ADR_FWU, 4'hf, {rng[31], 23'd0, rng[7:0]}, rd, lat);
        end

        // crate pps windows with the control bit on and off
        for (int i = 0; i < 6; i++) begin
            rng = xorshift32(rng);
            wb_access(1'b1, ADR_CONTROL, 4'hf, {31'd0, rng[0]}, rd, lat);
            idle_cycles(int'(rng[5:3]));
            pps = 1'b1;
            idle_cycles(8 + int'(rng[9:6]));
            pps = 1'b0;
            idle_cycles(12);
        end

        idle_cycles(40);
        if (trig_cmd_top_inst.assertions_inst.fail_count != 0) begin
            $display("Regression failed");
            $fatal(1, "a concurrent assertion on the DUT failed");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// File: verification/trig_cmd_assertions.sv
`timescale 1ns/1ps

module trig_cmd_assertions (
    input logic sysclk_i,
    input logic wb_rst_i,
    input logic wb_ack_i,
    input logic runrst_i,
    input logic runstop_i,
    input logic phase_i,
    input logic tvalid_i,
    input logic tready_i
);

    // number of failed assertions, read by the testbench
    int fail_count = 0;

    // ack is a single-cycle pulse
    ack_single: assert property (@(posedge sysclk_i) disable iff (wb_rst_i)
        wb_ack_i |=> !wb_ack_i)
        else begin
            fail_count++;
            $error("wb_ack_o stayed high for two cycles");
        end

    // one run command per word
    run_onehot: assert property (@(posedge sysclk_i) disable iff (wb_rst_i)
        !(runrst_i && runstop_i))
        else begin
            fail_count++;
            $error("runrst_o and runstop_o high together");
        end

    // run pulses only line up with a word load
    run_in_phase: assert property (@(posedge sysclk_i) disable iff (wb_rst_i)
        (runrst_i || runstop_i) |-> phase_i)
        else begin
            fail_count++;
            $error("run pulse outside a phase cycle");
        end

    // no ready without valid
    ready_needs_valid: assert property (@(posedge sysclk_i) disable iff (wb_rst_i)
        tready_i |-> tvalid_i)
        else begin
            fail_count++;
            $error("s_trig_tready_o without s_trig_tvalid_i");
        end

endmodule

// File: verification/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_o,
    output logic rst_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset over the first 4 rising edges, released on a falling edge
    initial begin
        rst_o = 1'b1;
        repeat (4) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

// File: verilog/trig_cmd_top.sv
`timescale 1ns/1ps

module trig_cmd_top import trig_cmd_pkg::*; (
    input  logic        sysclk_i,
    input  logic        wb_rst_i,
    // wishbone slave
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [7:0]  wb_adr_i,
    input  logic [3:0]  wb_sel_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    // crate pps, already in the sysclk domain
    input  logic        pps_i,
    // trigger stream
    input  logic        s_trig_tvalid_i,
    input  logic [15:0] s_trig_tdata_i,
    output logic        s_trig_tready_o,
    // run control pulses
    output logic        runrst_o,
    output logic        runstop_o,
    // link word and its update strobe
    output cmd_word_t   command_o,
    output logic        phase_o
);

    link_phase_t link;
    cmd_req_t    req;
    cmd_done_t   done;

    trig_cmd_phase_gen phase_gen_inst (
        .sysclk_i (sysclk_i),
        .wb_rst_i (wb_rst_i),
        .link_o   (link)
    );

    trig_cmd_wb_regs wb_regs_inst (
        .sysclk_i (sysclk_i),
        .wb_rst_i (wb_rst_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_sel_i (wb_sel_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o),
        .done_i   (done),
        .req_o    (req)
    );

    trig_cmd_encoder encoder_inst (
        .sysclk_i        (sysclk_i),
        .wb_rst_i        (wb_rst_i),
        .pps_i           (pps_i),
        .s_trig_tvalid_i (s_trig_tvalid_i),
        .s_trig_tdata_i  (s_trig_tdata_i),
        .req_i           (req),
        .link_i          (link),
        .done_o          (done),
        .s_trig_tready_o (s_trig_tready_o),
        .runrst_o        (runrst_o),
        .runstop_o       (runstop_o),
        .command_o       (command_o)
    );

    // command_o changes in the cycle after this strobe
    assign phase_o = link.phase;

endmodule

// File: verilog/trig_cmd_encoder.sv
`timescale 1ns/1ps

module trig_cmd_encoder import trig_cmd_pkg::*; (
    input  logic        sysclk_i,
    input  logic        wb_rst_i,
    input  logic        pps_i,
    input  logic        s_trig_tvalid_i,
    input  logic [15:0] s_trig_tdata_i,
    input  cmd_req_t    req_i,
    input  link_phase_t link_i,
    output cmd_done_t   done_o,
    output logic        s_trig_tready_o,
    output logic        runrst_o,
    output logic        runstop_o,
    output cmd_word_t   command_o
);

    // crate pps, gated by the control bit
    logic crate_pps;

    // runcmd request state
    logic    runcmd_pending;
    runcmd_e runcmd_data;
    // pending and inside a sync interval
    logic    runcmd_emit;
    runcmd_e runcmd_val;

    // fwu request state
    logic       fwu_pending;
    logic       fwu_mark;
    logic [7:0] fwu_data;

    // mode1 field for the next word
    mode1_e     mode1_type;
    logic [7:0] mode1_data;

    cmd_word_t word_d;
    cmd_word_t word_q;

    // runcmds only go out in the sync interval
    assign runcmd_emit = runcmd_pending && link_i.sync;
    assign runcmd_val  = runcmd_emit ? runcmd_data : RUN_NOOP;

    always_comb begin
        if (fwu_pending && !fwu_mark) begin
            mode1_type = MODE1_FWU_DATA;
            mode1_data = fwu_data;
        end else if (fwu_pending) begin
            // a mark rides in a noop field
            // bit 1 flags it, bit 0 carries its value
            mode1_type = MODE1_NOOP;
            mode1_data = {6'd0, 1'b1, fwu_data[0]};
        end else begin
            mode1_type = MODE1_NOOP;
            mode1_data = 8'd0;
        end
    end

    always_comb begin
        word_d.no_msg     = ~(runcmd_emit || fwu_pending || crate_pps);
        word_d.pps        = crate_pps;
        word_d.rsvd       = 2'b00;
        word_d.runcmd     = runcmd_val;
        word_d.mode1_type = mode1_type;
        word_d.mode1_data = mode1_data;
        // trigger is taken in the phase cycle, tdata bit 15 is not carried
        word_d.trig_valid = s_trig_tvalid_i;
        word_d.trig_addr  = s_trig_tdata_i[14:0];
    end

    always_ff @(posedge sysclk_i) begin
        if (wb_rst_i) begin
            crate_pps      <= 1'b0;
            runcmd_pending <= 1'b0;
            fwu_pending    <= 1'b0;
            word_q         <= '0;
        end else begin
            crate_pps <= pps_i && req_i.en_crate_pps;

            // a new request wins over retiring the old one
            if (req_i.send_runcmd) begin
                runcmd_pending <= 1'b1;
            end else if (link_i.phase && link_i.sync) begin
                runcmd_pending <= 1'b0;
            end

            // fwu goes out at the very next phase
            if (req_i.send_fwu) begin
                fwu_pending <= 1'b1;
            end else if (link_i.phase) begin
                fwu_pending <= 1'b0;
            end

            if (link_i.phase) begin
                word_q <= word_d;
            end
        end
    end

    // request payload, only meaningful while pending
    always_ff @(posedge sysclk_i) begin
        if (req_i.send_runcmd) begin
            runcmd_data <= runcmd_e'(req_i.hold_data[1:0]);
        end
        if (req_i.send_fwu) begin
            fwu_mark <= req_i.hold_mark;
            fwu_data <= req_i.hold_data;
        end
    end

    // done in the phase cycle that retires the request
    assign done_o.runcmd_done = runcmd_emit && link_i.phase;
    assign done_o.fwu_done    = fwu_pending && link_i.phase;

    assign s_trig_tready_o = s_trig_tvalid_i && link_i.phase;

    // run pulses line up with the word being loaded
    assign runrst_o  = link_i.phase && (runcmd_val == RUN_RESET);
    assign runstop_o = link_i.phase && (runcmd_val == RUN_STOP);

    assign command_o = word_q;

endmodule

// File: verilog/trig_cmd_wb_regs.sv
`timescale 1ns/1ps
`include "trig_cmd_defines.svh"

module trig_cmd_wb_regs import trig_cmd_pkg::*; (
    input  logic        sysclk_i,
    input  logic        wb_rst_i,
    input  logic        wb_cyc_i,
    input  logic        wb_stb_i,
    input  logic        wb_we_i,
    input  logic [7:0]  wb_adr_i,
    input  logic [3:0]  wb_sel_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,
    input  cmd_done_t   done_i,
    output cmd_req_t    req_o
);

    wb_state_e state_q;

    // slot decode from address bits 3:2
    logic adr_runcmd;
    logic adr_fwu;
    logic adr_control;
    logic adr_reserved;

    // bus request seen this cycle
    logic bus_req;

    // byte 0 and bit 31 of the last write
    logic [7:0] dat_hold;
    logic       mark_hold;

    // control bit 0
    logic en_crate_pps;

    assign adr_runcmd   = (wb_adr_i[3:2] == `TRIG_CMD_ADDR_RUNCMD);
    assign adr_fwu      = (wb_adr_i[3:2] == `TRIG_CMD_ADDR_FWU);
    assign adr_control  = (wb_adr_i[3:2] == `TRIG_CMD_ADDR_CONTROL);
    assign adr_reserved = (wb_adr_i[3:2] == `TRIG_CMD_ADDR_RESERVED);

    assign bus_req = wb_cyc_i && wb_stb_i;

    always_ff @(posedge sysclk_i) begin
        if (wb_rst_i) begin
            state_q <= WB_IDLE;
        end else begin
            case (state_q)
                WB_IDLE: begin
                    if (bus_req) begin
                        // control and reserved never go to the link
                        if (adr_control || adr_reserved) begin
                            state_q <= WB_ACK;
                        end else if (wb_we_i && wb_sel_i[0]) begin
                            state_q <= WB_ISSUE;
                        end else begin
                            // reads and byte-0-less writes ack at once
                            state_q <= WB_ACK;
                        end
                    end
                end
                WB_ISSUE: begin
                    state_q <= WB_WAIT;
                end
                WB_WAIT: begin
                    // hold the bus until the encoder retires the request
                    if (done_i.runcmd_done || done_i.fwu_done) begin
                        state_q <= WB_ACK;
                    end
                end
                default: begin
                    state_q <= WB_IDLE;
                end
            endcase
        end
    end

    // control register, written as the ack goes out
    always_ff @(posedge sysclk_i) begin
        if (wb_rst_i) begin
            en_crate_pps <= 1'b0;
        end else if (state_q == WB_ACK && adr_control && wb_we_i && wb_sel_i[0]) begin
            en_crate_pps <= wb_dat_i[0];
        end
    end

    // payload capture on the first cycle of a write
    always_ff @(posedge sysclk_i) begin
        if (state_q == WB_IDLE && bus_req && wb_we_i) begin
            if (wb_sel_i[0]) begin
                dat_hold <= wb_dat_i[7:0];
            end
            if (wb_sel_i[3]) begin
                mark_hold <= wb_dat_i[31];
            end
        end
    end

    // issue pulses, address is still held by the master
    assign req_o.send_runcmd  = (state_q == WB_ISSUE) && adr_runcmd;
    assign req_o.send_fwu     = (state_q == WB_ISSUE) && adr_fwu;
    assign req_o.hold_data    = dat_hold;
    assign req_o.hold_mark    = mark_hold;
    assign req_o.en_crate_pps = en_crate_pps;

    assign wb_ack_o = (state_q == WB_ACK);
    // every slot reads back the control bit
    assign wb_dat_o = {31'd0, en_crate_pps};

endmodule

// File: verilog/trig_cmd_phase_gen.sv
`timescale 1ns/1ps
`include "trig_cmd_defines.svh"

module trig_cmd_phase_gen import trig_cmd_pkg::*; (
    input  logic        sysclk_i,
    input  logic        wb_rst_i,
    output link_phase_t link_o
);

    localparam int PERIOD = `TRIG_CMD_PHASE_PERIOD;
    localparam int GROUP  = `TRIG_CMD_SYNC_PHASES;
    localparam int CYC_W  = $clog2(PERIOD);
    localparam int GRP_W  = $clog2(GROUP);

    // cycle position inside the current phase period
    logic [CYC_W-1:0] cyc_cnt;
    // phase position inside the sync group
    logic [GRP_W-1:0] grp_cnt;
    logic             phase;

    // strobe on the last cycle of each period
    // so the first one lands at cycle 7 after reset
    assign phase = (cyc_cnt == CYC_W'(PERIOD - 1));

    always_ff @(posedge sysclk_i) begin
        if (wb_rst_i) begin
            cyc_cnt <= '0;
            grp_cnt <= '0;
        end else begin
            // power-of-two period, counter wraps on its own
            cyc_cnt <= cyc_cnt + 1'b1;
            // advance the group count once per phase
            if (phase) begin
                grp_cnt <= grp_cnt + 1'b1;
            end
        end
    end

    assign link_o.phase = phase;
    // level over the whole last period of the group,
    // covers exactly one strobe in four
    assign link_o.sync = (grp_cnt == GRP_W'(GROUP - 1));

endmodule

// File: verilog/trig_cmd_pkg.sv
package trig_cmd_pkg;

    // run command field values
    typedef enum logic [1:0] {
        RUN_NOOP  = 2'd0,
        RUN_SYNC  = 2'd1,
        RUN_RESET = 2'd2,
        RUN_STOP  = 2'd3
    } runcmd_e;

    // mode1 field type, only two types are generated here
    typedef enum logic [1:0] {
        MODE1_NOOP     = 2'd0,
        MODE1_FWU_DATA = 2'd3
    } mode1_e;

    // wishbone slave states
    typedef enum logic [1:0] {
        WB_IDLE,
        WB_ISSUE,
        WB_WAIT,
        WB_ACK
    } wb_state_e;

    // link command word, msb first
    typedef struct packed {
        logic        no_msg;
        logic        pps;
        logic [1:0]  rsvd;
        runcmd_e     runcmd;
        mode1_e      mode1_type;
        logic [7:0]  mode1_data;
        logic        trig_valid;
        logic [14:0] trig_addr;
    } cmd_word_t;

    // register block to encoder
    // send bits are single-cycle pulses, the rest are levels
    typedef struct packed {
        logic       send_runcmd;
        logic       send_fwu;
        logic [7:0] hold_data;
        logic       hold_mark;
        logic       en_crate_pps;
    } cmd_req_t;

    // encoder back to register block, single-cycle pulses
    typedef struct packed {
        logic runcmd_done;
        logic fwu_done;
    } cmd_done_t;

    // phase strobe and sync level
    typedef struct packed {
        logic phase;
        logic sync;
    } link_phase_t;

endpackage

// File: verilog/trig_cmd_defines.svh
`ifndef TRIG_CMD_DEFINES_SVH
`define TRIG_CMD_DEFINES_SVH

// register slots, decoded on wishbone address bits 3:2

// run command port, write byte 0 bits 1:0
`define TRIG_CMD_ADDR_RUNCMD   2'd0
// fwu port, bit 31 picks mark (1) or data (0), byte 0 is the payload
`define TRIG_CMD_ADDR_FWU      2'd1
// control register, bit 0 enables crate pps
`define TRIG_CMD_ADDR_CONTROL  2'd2
// unused slot, acks and does nothing
`define TRIG_CMD_ADDR_RESERVED 2'd3

// link timing

// sysclk cycles per link phase, one command word per phase
`define TRIG_CMD_PHASE_PERIOD  8
// phases per sync group
// sync is high for the last phase period of the group
`define TRIG_CMD_SYNC_PHASES   4

`endif
